/* sim.f */
design/zcmp_pkg.sv
design/cm_decoder.sv
design/uop_sequencer.sv
design/uop_encoder.sv
design/zcmp_seq_top.sv
sim/cm_sequencer_chk.sv
sim/tb_zcmp_seq.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the Zcmp sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_zcmp_seq -f sim.f

./obj_dir/Vtb_zcmp_seq > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0

/* sim/tb_zcmp_seq.sv */
`timescale 1ns/1ps

module tb_zcmp_seq;

  import zcmp_pkg::*;

  // Cycles allowed for one sequence, stalls included
  localparam int SEQ_TIMEOUT = 400;

  logic        clk;
  logic        rst_n;
  logic [15:0] instr_i;
  logic        valid_i;
  logic        kill_i;
  logic        halt_i;
  logic        ready_i;
  logic        ready_o;
  logic        uop_valid_o;
  logic        seq_first_o;
  logic        seq_last_o;
  logic        illegal_o;
  logic [31:0] uop_instr_o;

  // Expected micro-ops of the instruction under test
  logic [31:0] exp_q[$];
  logic        failed;
  string       cur_test;

  zcmp_seq_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_i     (instr_i),
    .valid_i     (valid_i),
    .kill_i      (kill_i),
    .halt_i      (halt_i),
    .ready_i     (ready_i),
    .ready_o     (ready_o),
    .uop_valid_o (uop_valid_o),
    .seq_first_o (seq_first_o),
    .seq_last_o  (seq_last_o),
    .illegal_o   (illegal_o),
    .uop_instr_o (uop_instr_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // RV32I I-type word (addi, lw, jalr)
  function automatic logic [31:0] rv_i(input logic [6:0] opc, input logic [4:0] rd,
                                       input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    rv_i = {imm, rs1, f3, rd, opc};
  endfunction

  // sw rs2, imm(rs1)
  function automatic logic [31:0] rv_s(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    rv_s = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // ra, s0, s1, then s2 upward from x18
  function automatic logic [4:0] list_elem(input logic [11:0] i);
    case (i)
      12'd0:   list_elem = 5'd1;
      12'd1:   list_elem = 5'd8;
      12'd2:   list_elem = 5'd9;
      default: list_elem = 5'd18 + (i[4:0] - 5'd3);
    endcase
  endfunction

  // r1s'/r2s' field to x8, x9, x18..x23
  function automatic logic [4:0] sreg(input logic [2:0] c);
    sreg = (c < 3'd2) ? 5'd8 + {2'd0, c} : 5'd18 + ({2'd0, c} - 5'd2);
  endfunction

  function automatic logic [15:0] stack_instr(input seq_kind_e kind, input logic [3:0] rlist,
                                              input logic [1:0] spimm);
    logic [7:0] hi;
    case (kind)
      PUSH:    hi = 8'b101110_00;
      POP:     hi = 8'b101110_10;
      POPRETZ: hi = 8'b101111_00;
      default: hi = 8'b101111_10;
    endcase
    stack_instr = {hi, rlist, spimm, 2'b10};
  endfunction

  function automatic logic [15:0] move_instr(input seq_kind_e kind, input logic [2:0] a,
                                             input logic [2:0] b);
    move_instr = {6'b101011, a, (kind == MVSA01) ? 2'b01 : 2'b11, b, 2'b10};
  endfunction

  // Register transfers, sp update, optional a0 clear and ret
  function automatic void expect_stack(input seq_kind_e kind, input logic [3:0] rlist,
                                       input logic [1:0] spimm);
    logic [11:0] n;
    logic [11:0] adj;
    logic [11:0] i;
    logic [11:0] off;
    exp_q.delete();
    n = (rlist == 4'd15) ? 12'd13 : {8'd0, rlist} - 12'd3;
    // 16 bytes per started group of four registers
    adj = (((n + 12'd3) >> 2) << 4) + {6'd0, spimm, 4'd0};
    for (i = 12'd0; i < n; i++) begin
      off = (n - i) << 2;
      if (kind == PUSH) exp_q.push_back(rv_s(list_elem(i), 5'd2, 12'd0 - off));
      else exp_q.push_back(rv_i(7'h03, list_elem(i), 3'b010, 5'd2, adj - off));
    end
    exp_q.push_back(rv_i(7'h13, 5'd2, 3'b000, 5'd2, (kind == PUSH) ? 12'd0 - adj : adj));
    if (kind == POPRETZ) exp_q.push_back(rv_i(7'h13, 5'd10, 3'b000, 5'd0, 12'd0));
    if (kind == POPRET || kind == POPRETZ) begin
      exp_q.push_back(rv_i(7'h67, 5'd0, 3'b000, 5'd1, 12'd0));
    end
  endfunction

  function automatic void expect_move(input seq_kind_e kind, input logic [2:0] a,
                                      input logic [2:0] b);
    exp_q.delete();
    if (kind == MVSA01) begin
      exp_q.push_back(rv_i(7'h13, sreg(a), 3'b000, 5'd10, 12'd0));
      exp_q.push_back(rv_i(7'h13, sreg(b), 3'b000, 5'd11, 12'd0));
    end else begin
      exp_q.push_back(rv_i(7'h13, 5'd10, 3'b000, sreg(a), 12'd0));
      exp_q.push_back(rv_i(7'h13, 5'd11, 3'b000, sreg(b), 12'd0));
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Error reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    failed = 1'b1;
    $display("Mismatch at %0t ns in %s: %s", $time, cur_test, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_failure(input string msg);
    failed = 1'b1;
    $display("Error in %s: %s", cur_test, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_uop(input logic [31:0] got, input logic got_last,
                             input logic [31:0] exp, input logic exp_last);
    if (got !== exp) report_mismatch($sformatf("uop 0x%08h, expected 0x%08h", got, exp));
    if (got_last !== exp_last) begin
      report_mismatch($sformatf("seq_last_o %0b, expected %0b", got_last, exp_last));
    end
  endtask

  task automatic compare_kind(input logic got_illegal, input logic exp_illegal);
    if (got_illegal !== exp_illegal) begin
      report_mismatch($sformatf("illegal_o %0b, expected %0b", got_illegal, exp_illegal));
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string name);
    if (got !== exp) report_mismatch($sformatf("%s %0b, expected %0b", name, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence driver
  ////////////////////////////////////////////////////////////

  // Runs exp_q through the DUT, halt for 3 cycles after halt_at transfers,
  // returns early with valid still high after stop_at transfers
  task automatic run_seq(input logic [15:0] instr, input bit use_bp, input int halt_at,
                         input int stop_at);
    int          idx;
    int          cycles;
    int          len;
    int          halt_left;
    logic [31:0] rnd;
    len = exp_q.size();
    idx = 0;
    cycles = 0;
    halt_left = 3;
    rnd = $urandom();
    @(posedge clk);
    instr_i <= instr;
    valid_i <= 1'b1;
    ready_i <= use_bp ? rnd[0] : 1'b1;
    while (idx < len && idx != stop_at) begin
      @(negedge clk);
      cycles++;
      if (cycles > SEQ_TIMEOUT) report_failure("sequence did not finish before the timeout");
      compare_kind(illegal_o, 1'b0);
      compare_flag(uop_valid_o, !halt_i, "uop_valid_o");
      compare_flag(seq_first_o, idx == 0, "seq_first_o");
      compare_flag(ready_o, !halt_i && ready_i && (idx == len - 1), "ready_o");
      // Data must hold its step through stalls and halts
      compare_uop(uop_instr_o, seq_last_o, exp_q[idx], idx == len - 1);
      // Step moves on a transfer as seen at the DUT ports
      if (uop_valid_o && ready_i) idx++;
      if (idx != stop_at) begin
        @(posedge clk);
        rnd = $urandom();
        if (idx == len) valid_i <= 1'b0;
        ready_i <= use_bp ? rnd[0] : 1'b1;
        halt_i <= (idx == halt_at) && (halt_left > 0);
        if (idx == halt_at && halt_left > 0) halt_left--;
      end
    end
    if (!use_bp && halt_at < 0 && stop_at < 0 && cycles != len) begin
      report_mismatch($sformatf("sequence took %0d cycles, expected %0d", cycles, len));
    end
  endtask

  task automatic run_stack(input seq_kind_e kind, input logic [3:0] rlist,
                           input logic [1:0] spimm, input bit use_bp, input int halt_at,
                           input int stop_at);
    expect_stack(kind, rlist, spimm);
    run_seq(stack_instr(kind, rlist, spimm), use_bp, halt_at, stop_at);
  endtask

  // One-cycle kill on the instruction left in flight
  task automatic apply_kill();
    @(posedge clk);
    kill_i <= 1'b1;
    @(negedge clk);
    compare_flag(ready_o, 1'b1, "ready_o under kill");
    compare_flag(uop_valid_o, 1'b0, "uop_valid_o under kill");
    @(posedge clk);
    kill_i <= 1'b0;
    valid_i <= 1'b0;
  endtask

  // Illegal words are consumed at once with no micro-op
  task automatic check_illegal(input logic [15:0] instr);
    logic [31:0] rnd;
    rnd = $urandom();
    @(posedge clk);
    instr_i <= instr;
    valid_i <= 1'b1;
    ready_i <= rnd[0];
    @(negedge clk);
    compare_kind(illegal_o, 1'b1);
    compare_flag(ready_o, 1'b1, "ready_o on illegal");
    compare_flag(uop_valid_o, 1'b0, "uop_valid_o on illegal");
    @(posedge clk);
    valid_i <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_stack_all();
    logic [31:0] rnd;
    int          r;
    for (r = 4; r <= 15; r++) begin
      rnd = $urandom();
      cur_test = "push";
      run_stack(PUSH, r[3:0], rnd[1:0], 1'b0, -1, -1);
      cur_test = "pop";
      run_stack(POP, r[3:0], rnd[3:2], 1'b0, -1, -1);
      cur_test = "popret";
      run_stack(POPRET, r[3:0], rnd[5:4], 1'b0, -1, -1);
      cur_test = "popretz";
      run_stack(POPRETZ, r[3:0], rnd[7:6], 1'b0, -1, -1);
    end
  endtask

  task automatic test_moves();
    int a;
    int b;
    cur_test = "moves";
    for (a = 0; a < 8; a++) begin
      for (b = 0; b < 8; b++) begin
        expect_move(MVSA01, a[2:0], b[2:0]);
        run_seq(move_instr(MVSA01, a[2:0], b[2:0]), 1'b0, -1, -1);
        expect_move(MVA01S, a[2:0], b[2:0]);
        run_seq(move_instr(MVA01S, a[2:0], b[2:0]), 1'b0, -1, -1);
      end
    end
  endtask

  task automatic test_backpressure();
    logic [31:0] rnd;
    cur_test = "backpressure";
    rnd = $urandom();
    run_stack(POPRETZ, 4'd15, rnd[1:0], 1'b1, -1, -1);
    run_stack(PUSH, 4'd15, rnd[3:2], 1'b1, -1, -1);
    run_stack(POP, 4'd13, rnd[5:4], 1'b1, -1, -1);
    run_stack(POPRET, 4'd9, rnd[7:6], 1'b1, -1, -1);
    expect_move(MVA01S, 3'd2, 3'd7);
    run_seq(move_instr(MVA01S, 3'd2, 3'd7), 1'b1, -1, -1);
  endtask

  task automatic test_halt_kill();
    cur_test = "halt";
    run_stack(POP, 4'd10, 2'd1, 1'b0, 3, -1);
    run_stack(POPRETZ, 4'd15, 2'd2, 1'b0, 14, -1);
    cur_test = "kill";
    run_stack(PUSH, 4'd12, 2'd0, 1'b0, -1, 4);
    apply_kill();
    // Fresh instructions start again at step 0
    run_stack(POP, 4'd6, 2'd3, 1'b0, -1, -1);
    run_stack(POPRET, 4'd11, 2'd0, 1'b0, -1, 0);
    apply_kill();
    run_stack(PUSH, 4'd12, 2'd0, 1'b0, -1, -1);
  endtask

  task automatic test_illegal();
    int r;
    cur_test = "illegal";
    for (r = 0; r < 4; r++) begin
      check_illegal(stack_instr(PUSH, r[3:0], 2'd1));
      check_illegal(stack_instr(POP, r[3:0], 2'd0));
      check_illegal(stack_instr(POPRET, r[3:0], 2'd2));
      check_illegal(stack_instr(POPRETZ, r[3:0], 2'd3));
    end
    // Reserved bits 9:8, move selects and quadrants
    check_illegal(16'b101110_01_0100_00_10);
    check_illegal(16'b101110_11_0101_00_10);
    check_illegal(16'b101111_01_0110_01_10);
    check_illegal(16'b101111_11_1111_00_10);
    check_illegal(16'b101011_010_00_011_10);
    check_illegal(16'b101011_001_10_100_10);
    check_illegal(16'b101100_00_0100_00_10);
    check_illegal(16'b101110_00_0100_00_00);
    check_illegal(16'b101110_10_0111_00_01);
    check_illegal(16'b101011_000_01_001_11);
  endtask

  initial begin
    void'($urandom(32'h1858));
    failed = 1'b0;
    cur_test = "reset";
    rst_n = 1'b0;
    instr_i = '0;
    valid_i = 1'b0;
    kill_i = 1'b0;
    halt_i = 1'b0;
    ready_i = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // Quiet until the first valid
    @(negedge clk);
    compare_flag(uop_valid_o, 1'b0, "uop_valid_o after reset");
    compare_flag(ready_o, 1'b0, "ready_o after reset");
    compare_flag(seq_last_o, 1'b0, "seq_last_o after reset");
    compare_kind(illegal_o, 1'b0);
    test_stack_all();
    test_moves();
    test_backpressure();
    test_halt_kill();
    test_illegal();
    repeat (2) @(posedge clk);
    if (!failed) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* sim/cm_sequencer_chk.sv */
`timescale 1ns/1ps

module cm_sequencer_chk (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 valid_i,
  input logic                 kill_i,
  input logic                 halt_i,
  input logic                 ready_i,
  input logic                 valid_o,
  input logic                 ready_o,
  input logic                 seq_last_o,
  input zcmp_pkg::seq_kind_e  seq_kind_i,
  input zcmp_pkg::seq_cnt_t   seq_cnt_q,
  input zcmp_pkg::seq_state_e seq_state_q,
  input logic [4:0]           seq_len
);

  import zcmp_pkg::*;

  // Kill returns the FSM to idle at step 0
  kill_clears: assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |=> (seq_state_q == S_IDLE) && (seq_cnt_q == '0))
    else $error("sequencer not idle after kill");

  // Last transfer ends the sequence
  last_clears: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_o && ready_i && seq_last_o) |=> (seq_state_q == S_IDLE) && (seq_cnt_q == '0))
    else $error("sequencer not idle after last transfer");

  kill_handshake: assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |-> ready_o && !valid_o)
    else $error("kill did not force ready high and valid low");

  halt_handshake: assert property (@(posedge clk) disable iff (!rst_n)
    (halt_i && !kill_i) |-> !ready_o && !valid_o)
    else $error("halt did not force ready and valid low");

  // Frozen under halt
  halt_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (halt_i && !kill_i) |=> $stable(seq_cnt_q) && $stable(seq_state_q))
    else $error("counter moved under halt");

  // Step never reaches the length of the current sequence
  cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_i && (seq_kind_i != INVALID_INST)) |-> ({1'b0, seq_cnt_q} < seq_len))
    else $error("step counter beyond sequence length");

endmodule

bind uop_sequencer cm_sequencer_chk u_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .valid_i     (valid_i),
  .kill_i      (kill_i),
  .halt_i      (halt_i),
  .ready_i     (ready_i),
  .valid_o     (valid_o),
  .ready_o     (ready_o),
  .seq_last_o  (seq_last_o),
  .seq_kind_i  (seq_kind_i),
  .seq_cnt_q   (seq_cnt_q),
  .seq_state_q (seq_state_q),
  .seq_len     (seq_len)
);

/* design/zcmp_seq_top.sv */
`timescale 1ns/1ps

module zcmp_seq_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] instr_i,
  input  logic        valid_i,
  input  logic        kill_i,
  input  logic        halt_i,
  input  logic        ready_i,
  output logic        ready_o,
  output logic        uop_valid_o,
  output logic        seq_first_o,
  output logic        seq_last_o,
  output logic        illegal_o,
  output logic [31:0] uop_instr_o
);

  import zcmp_pkg::*;

  // Decode results, combinational from instr_i
  seq_kind_e  seq_kind;
  rlist_cnt_t n_regs;
  stack_adj_t stack_adj;
  logic [4:0] r1s;
  logic [4:0] r2s;
  // Current micro-op index
  seq_cnt_t   step;

  ////////////////////////////////////////////////////////////
  // Decode, sequence, encode
  ////////////////////////////////////////////////////////////

  cm_decoder u_dec (
    .instr_i     (instr_i),
    .seq_kind_o  (seq_kind),
    .n_regs_o    (n_regs),
    .stack_adj_o (stack_adj),
    .r1s_o       (r1s),
    .r2s_o       (r2s)
  );

  uop_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (valid_i),
    .kill_i      (kill_i),
    .halt_i      (halt_i),
    .ready_i     (ready_i),
    .seq_kind_i  (seq_kind),
    .n_regs_i    (n_regs),
    .valid_o     (uop_valid_o),
    .ready_o     (ready_o),
    .seq_first_o (seq_first_o),
    .seq_last_o  (seq_last_o),
    .illegal_o   (illegal_o),
    .step_o      (step)
  );

  uop_encoder u_enc (
    .seq_kind_i  (seq_kind),
    .step_i      (step),
    .n_regs_i    (n_regs),
    .stack_adj_i (stack_adj),
    .r1s_i       (r1s),
    .r2s_i       (r2s),
    .uop_instr_o (uop_instr_o)
  );

endmodule

/* design/uop_encoder.sv */
`timescale 1ns/1ps

module uop_encoder (
  input  zcmp_pkg::seq_kind_e  seq_kind_i,
  input  zcmp_pkg::seq_cnt_t   step_i,
  input  zcmp_pkg::rlist_cnt_t n_regs_i,
  input  zcmp_pkg::stack_adj_t stack_adj_i,
  input  logic [4:0]           r1s_i,
  input  logic [4:0]           r2s_i,
  output logic [31:0]          uop_instr_o
);

  import zcmp_pkg::*;

  // Step is a register load or store
  logic        reg_step;
  // Steps past the register list, 0 is the sp update
  seq_cnt_t    tail;
  logic [4:0]  list_rd;
  // 4*(step-n), negative within the list
  logic [11:0] rel_off;
  logic [11:0] pop_off;
  logic [11:0] neg_adj;
  logic [11:0] pos_adj;

  // I-type word, also covers lw and jalr
  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    enc_i = {imm, rs1, f3, rd, opc};
  endfunction

  // S-type word for sw
  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    enc_s = {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
  endfunction

  // List order ra, s0-s1, s2-s11
  function automatic logic [4:0] list_reg(input seq_cnt_t idx);
    if (idx == 4'd0) begin
      list_reg = REG_RA;
    end else if (idx < 4'd3) begin
      list_reg = 5'd7 + {1'b0, idx};
    end else begin
      list_reg = 5'd15 + {1'b0, idx};
    end
  endfunction

  assign reg_step = (step_i < n_regs_i);
  assign tail     = step_i - n_regs_i;
  assign list_rd  = list_reg(step_i);

  // Offsets and sp adjustments as 12-bit immediates
  assign rel_off = {6'd0, step_i, 2'b00} - {6'd0, n_regs_i, 2'b00};
  assign pos_adj = {5'd0, stack_adj_i};
  assign pop_off = pos_adj + rel_off;
  assign neg_adj = 12'd0 - pos_adj;

  ////////////////////////////////////////////////////////////
  // Micro-op select and assembly
  ////////////////////////////////////////////////////////////

  always_comb begin
    // nop outside any sequence
    uop_instr_o = enc_i(12'd0, REG_ZERO, F3_ADDI, REG_ZERO, OPC_OP_IMM);
    case (seq_kind_i)
      PUSH: begin
        if (reg_step) uop_instr_o = enc_s(rel_off, list_rd, REG_SP);
        else if (tail == 4'd0) uop_instr_o = enc_i(neg_adj, REG_SP, F3_ADDI, REG_SP, OPC_OP_IMM);
      end
      POP, POPRET, POPRETZ: begin
        if (reg_step) begin
          uop_instr_o = enc_i(pop_off, REG_SP, F3_WORD, list_rd, OPC_LOAD);
        end else if (tail == 4'd0) begin
          uop_instr_o = enc_i(pos_adj, REG_SP, F3_ADDI, REG_SP, OPC_OP_IMM);
        end else if ((seq_kind_i == POPRETZ) && (tail == 4'd1)) begin
          // li a0, 0
          uop_instr_o = enc_i(12'd0, REG_ZERO, F3_ADDI, REG_A0, OPC_OP_IMM);
        end else if (seq_kind_i != POP) begin
          // ret
          uop_instr_o = enc_i(12'd0, REG_RA, F3_ADDI, REG_ZERO, OPC_JALR);
        end
      end
      // mv s, a
      MVSA01: begin
        if (step_i == 4'd0) uop_instr_o = enc_i(12'd0, REG_A0, F3_ADDI, r1s_i, OPC_OP_IMM);
        else uop_instr_o = enc_i(12'd0, REG_A1, F3_ADDI, r2s_i, OPC_OP_IMM);
      end
      // mv a, s
      MVA01S: begin
        if (step_i == 4'd0) uop_instr_o = enc_i(12'd0, r1s_i, F3_ADDI, REG_A0, OPC_OP_IMM);
        else uop_instr_o = enc_i(12'd0, r2s_i, F3_ADDI, REG_A1, OPC_OP_IMM);
      end
      default: ;
    endcase
  end

endmodule

/* design/uop_sequencer.sv */
`timescale 1ns/1ps

module uop_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 valid_i,
  input  logic                 kill_i,
  input  logic                 halt_i,
  input  logic                 ready_i,
  input  zcmp_pkg::seq_kind_e  seq_kind_i,
  input  zcmp_pkg::rlist_cnt_t n_regs_i,
  output logic                 valid_o,
  output logic                 ready_o,
  output logic                 seq_first_o,
  output logic                 seq_last_o,
  output logic                 illegal_o,
  output zcmp_pkg::seq_cnt_t   step_o
);

  import zcmp_pkg::*;

  seq_cnt_t   seq_cnt_q;
  seq_state_e seq_state_q;

  // Total micro-ops for the current instruction, up to 16
  logic [4:0] seq_len;
  // Decoded instruction is a real Zcmp sequence
  logic       kind_ok;
  logic       last_step;
  // Downstream transfer this cycle
  logic       xfer;

  ////////////////////////////////////////////////////////////
  // Sequence length
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (seq_kind_i)
      // Register transfers plus sp update
      PUSH, POP: seq_len = {1'b0, n_regs_i} + 5'd1;
      // Plus return
      POPRET:    seq_len = {1'b0, n_regs_i} + 5'd2;
      // Plus a0 clear and return
      POPRETZ:   seq_len = {1'b0, n_regs_i} + 5'd3;
      MVSA01, MVA01S: seq_len = LEN_MV;
      default:   seq_len = 5'd0;
    endcase
  end

  assign kind_ok   = (seq_kind_i != INVALID_INST);
  assign last_step = ({1'b0, seq_cnt_q} == (seq_len - 5'd1));

  ////////////////////////////////////////////////////////////
  // Handshake and flags
  ////////////////////////////////////////////////////////////

  // Combinational valid, halt and kill both suppress it
  assign valid_o = valid_i && kind_ok && !halt_i && !kill_i;
  assign xfer    = valid_o && ready_i;

  assign seq_first_o = valid_i && kind_ok && (seq_state_q == S_IDLE);
  assign seq_last_o  = valid_i && kind_ok && last_step;
  assign illegal_o   = valid_i && !kind_ok;

  // Kill drops the instruction at once
  // Otherwise consume on the final transfer, or straight away if illegal
  assign ready_o = kill_i ||
                   (!halt_i && valid_i && (!kind_ok || (ready_i && last_step)));

  assign step_o = seq_cnt_q;

  ////////////////////////////////////////////////////////////
  // Step counter and state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seq_cnt_q   <= '0;
      seq_state_q <= S_IDLE;
    end else if (kill_i) begin
      seq_cnt_q   <= '0;
      seq_state_q <= S_IDLE;
    end else if (xfer) begin
      if (last_step) begin
        // Back to step 0 for the next instruction
        seq_cnt_q   <= '0;
        seq_state_q <= S_IDLE;
      end else begin
        seq_cnt_q   <= seq_cnt_q + 4'd1;
        seq_state_q <= S_SEQ;
      end
    end
    // Halt or back-pressure: counter and state hold
  end

endmodule

/* design/cm_decoder.sv */
`timescale 1ns/1ps

module cm_decoder (
  input  logic [15:0]          instr_i,
  output zcmp_pkg::seq_kind_e  seq_kind_o,
  output zcmp_pkg::rlist_cnt_t n_regs_o,
  output zcmp_pkg::stack_adj_t stack_adj_o,
  output logic [4:0]           r1s_o,
  output logic [4:0]           r2s_o
);

  import zcmp_pkg::*;

  // Instruction fields
  logic [3:0] rlist;
  logic [1:0] spimm;
  logic       rlist_ok;
  // n*4 rounded up to a multiple of 16
  logic [6:0] adj_base;

  // Compressed saved-register index to register number
  // 0..1 are s0..s1 (x8..x9), 2..7 are s2..s7 (x18..x23)
  function automatic logic [4:0] map_sreg(input logic [2:0] idx);
    if (idx[2:1] == 2'b00) begin
      map_sreg = 5'd8 + {2'b00, idx};
    end else begin
      map_sreg = 5'd16 + {2'b00, idx};
    end
  endfunction

  assign rlist = instr_i[7:4];
  assign spimm = instr_i[3:2];

  // Below 4 is reserved, RV32E stops at s1
  assign rlist_ok = (rlist >= RLIST_MIN) && (!IS_RV32E || (rlist <= RLIST_MAX_E));

  ////////////////////////////////////////////////////////////
  // Instruction class
  ////////////////////////////////////////////////////////////

  always_comb begin
    seq_kind_o = INVALID_INST;
    if (instr_i[1:0] == 2'b10) begin
      case (instr_i[15:10])
        // push and pop share the funct6, bits 9:8 split them
        6'b101110: begin
          if (instr_i[9:8] == 2'b00) seq_kind_o = PUSH;
          else if (instr_i[9:8] == 2'b10) seq_kind_o = POP;
        end
        6'b101111: begin
          if (instr_i[9:8] == 2'b00) seq_kind_o = POPRETZ;
          else if (instr_i[9:8] == 2'b10) seq_kind_o = POPRET;
        end
        // Moves, bits 6:5 select direction
        6'b101011: begin
          if (instr_i[6:5] == 2'b01) seq_kind_o = MVSA01;
          else if (instr_i[6:5] == 2'b11) seq_kind_o = MVA01S;
        end
        default: seq_kind_o = INVALID_INST;
      endcase
    end
    // Push/pop family with a bad rlist is illegal
    if ((seq_kind_o inside {PUSH, POP, POPRET, POPRETZ}) && !rlist_ok) begin
      seq_kind_o = INVALID_INST;
    end
  end

  ////////////////////////////////////////////////////////////
  // Register count, stack adjustment, move registers
  ////////////////////////////////////////////////////////////

  // rlist 15 covers s10 and s11 together
  assign n_regs_o = (rlist == 4'd15) ? 4'd13 : (rlist - 4'd3);

  assign adj_base    = ({1'b0, n_regs_o, 2'b00} + 7'd15) & 7'h70;
  assign stack_adj_o = adj_base + {1'b0, spimm, 4'b0000};

  assign r1s_o = map_sreg(instr_i[9:7]);
  assign r2s_o = map_sreg(instr_i[4:2]);

endmodule

/* design/zcmp_pkg.sv */
package zcmp_pkg;

  ////////////////////////////////////////////////////////////
  // Sequence kinds and sequencer state
  ////////////////////////////////////////////////////////////

  // Zcmp instruction class, INVALID_INST for anything else
  typedef enum logic [2:0] {
    INVALID_INST,
    PUSH,
    POP,
    POPRET,
    POPRETZ,
    MVSA01,
    MVA01S
  } seq_kind_e;

  // Idle until the first micro-op transfers
  typedef enum logic {
    S_IDLE,
    S_SEQ
  } seq_state_e;

  // Step counter, longest sequence is popretz with 13 registers (16 steps)
  typedef logic [3:0] seq_cnt_t;

  // Number of registers in rlist, 1 to 13
  typedef logic [3:0] rlist_cnt_t;

  // Stack adjustment in bytes, 16 to 112
  typedef logic [6:0] stack_adj_t;

  ////////////////////////////////////////////////////////////
  // Configuration and register-list limits
  ////////////////////////////////////////////////////////////

  // Embedded base ISA, only ra, s0 and s1 exist as saved registers
  localparam logic IS_RV32E = 1'b0;

  // Smallest legal rlist value (ra only)
  localparam logic [3:0] RLIST_MIN = 4'd4;
  // Largest legal rlist value on RV32E (ra, s0, s1)
  localparam logic [3:0] RLIST_MAX_E = 4'd6;

  // Both move instructions are two addi micro-ops
  localparam logic [4:0] LEN_MV = 5'd2;

  ////////////////////////////////////////////////////////////
  // Register numbers and RV32I encoding fields
  ////////////////////////////////////////////////////////////

  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;
  localparam logic [4:0] REG_A0   = 5'd10;
  localparam logic [4:0] REG_A1   = 5'd11;

  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // Word access for lw and sw
  localparam logic [2:0] F3_WORD = 3'b010;
  // addi and jalr share funct3
  localparam logic [2:0] F3_ADDI = 3'b000;

endpackage
